//--- spiUnit.f
hdl/usiBusPkg.sv
hdl/spiPkg.sv
hdl/ckeGenerator.sv
hdl/spiShifter.sv
hdl/spiCsr.sv
hdl/spiReadSequencer.sv
hdl/spiUnit.sv
testbench/spiFlashModel.sv
testbench/spiUnitAssert.sv
testbench/spiUnitTb.sv

//--- Makefile
SRCS := $(shell cat spiUnit.f)

all: run

obj_dir/VspiUnitTb: spiUnit.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module spiUnitTb -f spiUnit.f

run: obj_dir/VspiUnitTb
	./obj_dir/VspiUnitTb | tee sim.log
	@if grep -q "=== FAIL ===" sim.log; then exit 1; fi
	@grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- testbench/spiUnitTb.sv
// Testbench for the SPI read engine with a behavioral flash on the pins.
// Inputs change and outputs are sampled on the falling clock edge.
// The run length is bounded by a watchdog sized from the planned transfers.

`default_nettype none

module spiUnitTb;

	timeunit 1ns;
	timeprecision 100ps;

	import usiBusPkg::*;
	import spiPkg::*;

	logic      sysClk;
	logic      rst;
	axiReq_t   axiReq;
	axiRsp_t   axiRsp;
	logic      spiSck;
	logic      spiMosi;
	logic      spiMiso;
	logic      spiCsN;
	usiWrite_t usiWr;
	logic      usiMonopoly;

	// Scoreboard
	usiWrite_t       capQ[$];
	logic [15:0]     expAdrs[$];
	logic [31:0]     expData[$];
	logic [31:0]     expHead;
	int              valErrors;
	int              otherErrors;
	int              checks;
	int              curDiv;
	int              hiCnt;
	logic [31:0]     rng;
	// Random transfer table and watchdog budget
	int              rndCount[10];
	logic [23:0]     rndAdrs[10];
	logic [15:0]     rndDest[10];
	longint          budget;
	logic [31:0]     rd;

	spiUnit #(.divWidth(16)) dut_i (
		.sysClk(sysClk), .rst(rst), .axiReq(axiReq), .axiRsp(axiRsp),
		.spiSck(spiSck), .spiMosi(spiMosi), .spiMiso(spiMiso), .spiCsN(spiCsN),
		.usiWr(usiWr), .usiMonopoly(usiMonopoly)
	);

	spiFlashModel flash_i (.sck(spiSck), .csN(spiCsN), .mosi(spiMosi), .miso(spiMiso));

	always #50 sysClk = ~sysClk;

	//----------------------------------------------------------------------
	// Reference model and helpers
	//----------------------------------------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Expected word idx of a transfer under the flash data rule
	function automatic logic [31:0] expectWord(input logic [23:0] base, input int idx,
	                                           input int count);
		logic [31:0] w;
		logic [23:0] a;
		w = '0;
		for (int b = 0; b < 4; b++)
		begin
			if (idx * 4 + b < count)
			begin
				a = base + 24'(idx * 4 + b);
				w[b*8 +: 8] = 8'(a * 7 + 8'h5A);
			end
		end
		return w;
	endfunction

	task automatic checkUsiWrite(input usiWrite_t got);
		logic [15:0] ea;
		logic [31:0] ed;
		checks++;
		if (expAdrs.size() == 0)
		begin
			$display("ERROR: unexpected USI write at time %0t", $time);
			otherErrors++;
		end
		else
		begin
			ea = expAdrs.pop_front();
			ed = expData.pop_front();
			if (got.adrs !== ea || got.data !== ed)
			begin
				$display("FAIL %0t: USI write %h:%h, expected %h:%h",
				         $time, got.adrs, got.data, ea, ed);
				valErrors++;
			end
		end
	endtask

	task automatic checkAxiRead(input logic [31:0] got, input logic [31:0] exp,
	                            input string what);
		checks++;
		if (got !== exp)
		begin
			$display("FAIL %0t: %s read %h, expected %h", $time, what, got, exp);
			valErrors++;
		end
	endtask

	// AXI response code, OKAY expected
	task automatic checkResp(input logic [1:0] got, input string what);
		checks++;
		if (got !== 2'b00)
		begin
			$display("FAIL %0t: %s response %b, expected OKAY", $time, what, got);
			valErrors++;
		end
	endtask

	// Opcode and address as seen by the flash
	task automatic checkCommand(input logic [31:0] got);
		checks++;
		if (got !== expHead)
		begin
			$display("FAIL %0t: flash command %h, expected %h", $time, got, expHead);
			valErrors++;
		end
	endtask

	task automatic checkPin(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp)
		begin
			$display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
			valErrors++;
		end
	endtask

	//----------------------------------------------------------------------
	// AXI4-Lite host
	//----------------------------------------------------------------------
	task automatic axiWrite(input logic [7:0] adrs, input logic [31:0] data);
		@(negedge sysClk);
		axiReq.awaddr  = adrs;
		axiReq.wdata   = data;
		axiReq.wstrb   = 4'hF;
		axiReq.awvalid = 1'b1;
		axiReq.wvalid  = 1'b1;
		axiReq.bready  = 1'b1;
		while (!axiRsp.awready)
			@(negedge sysClk);
		@(negedge sysClk);
		axiReq.awvalid = 1'b0;
		axiReq.wvalid  = 1'b0;
		while (!axiRsp.bvalid)
			@(negedge sysClk);
		checkResp(axiRsp.bresp, "write");
		@(negedge sysClk);
		axiReq.bready = 1'b0;
	endtask

	task automatic axiRead(input logic [7:0] adrs, output logic [31:0] data);
		@(negedge sysClk);
		axiReq.araddr  = adrs;
		axiReq.arvalid = 1'b1;
		axiReq.rready  = 1'b1;
		while (!axiRsp.arready)
			@(negedge sysClk);
		@(negedge sysClk);
		axiReq.arvalid = 1'b0;
		while (!axiRsp.rvalid)
			@(negedge sysClk);
		data = axiRsp.rdata;
		checkResp(axiRsp.rresp, "read");
		@(negedge sysClk);
		axiReq.rready = 1'b0;
	endtask

	//----------------------------------------------------------------------
	// Transfer control
	//----------------------------------------------------------------------
	// Program registers, queue expected writes, then start
	task automatic startTransfer(input logic [23:0] fa, input int count,
	                             input logic [15:0] dest, input int div);
		curDiv  = div;
		expHead = {8'h03, fa};
		axiWrite(csrDiv, 32'(div));
		axiWrite(csrAdrs, 32'(fa));
		axiWrite(csrLen, 32'(count - 1));
		axiWrite(csrDest, 32'(dest));
		for (int i = 0; i < (count + 3) / 4; i++)
		begin
			expAdrs.push_back(dest + 16'(i * 4));
			expData.push_back(expectWord(fa, i, count));
		end
		axiWrite(csrCtrl, 32'h1);
	endtask

	task automatic waitTransfer();
		while (!usiMonopoly)
			@(negedge sysClk);
		while (usiMonopoly)
			@(negedge sysClk);
		// Let the compare process drain
		repeat (3) @(negedge sysClk);
		checkCommand(flash_i.head);
		if (expAdrs.size() != 0)
		begin
			$display("ERROR: %0d USI writes missing at time %0t", expAdrs.size(), $time);
			otherErrors++;
			expAdrs.delete();
			expData.delete();
		end
	endtask

	// Monitor
	always @(negedge sysClk)
		if (!rst && usiWr.cke)
			capQ.push_back(usiWr);

	// Compare
	always @(negedge sysClk)
		while (capQ.size() > 0)
			checkUsiWrite(capQ.pop_front());

	// SCK high time in clocks
	always @(negedge sysClk)
	begin
		if (spiSck)
			hiCnt++;
		else if (hiCnt != 0)
		begin
			checks++;
			if (hiCnt != curDiv + 1)
			begin
				$display("FAIL %0t: SCK high %0d clocks, expected %0d",
				         $time, hiCnt, curDiv + 1);
				valErrors++;
			end
			hiCnt = 0;
		end
	end

	// Watchdog
	initial
	begin
		wait (budget > 0);
		#(budget * 100);
		$display("ERROR: watchdog expired after %0d clocks", budget);
		$display("=== FAIL ===");
		$finish;
	end

	//----------------------------------------------------------------------
	// Main sequence
	//----------------------------------------------------------------------
	initial
	begin
		sysClk      = 1'b0;
		rst         = 1'b1;
		axiReq      = '0;
		valErrors   = 0;
		otherErrors = 0;
		checks      = 0;
		curDiv      = 1;
		hiCnt       = 0;
		budget      = 0;
		expHead     = '0;

		// Random table ahead of the budget that covers it
		rng = 32'd78;
		for (int i = 0; i < 10; i++)
		begin
			rng         = xorshift(rng);
			rndCount[i] = int'(rng % 64) + 1;
			rng         = xorshift(rng);
			rndAdrs[i]  = rng[23:0];
			rng         = xorshift(rng);
			rndDest[i]  = {rng[15:2], 2'b00};
		end
		budget = (1 + 4) * 16 * 2 + (8 + 4) * 16 * 4 + (8 + 4) * 16 * 10
		         + (16 + 4) * 16 * 2 + (4 + 4) * 16 * 2;
		for (int i = 0; i < 10; i++)
			budget += (rndCount[i] + 4) * 16 * 2;
		budget = budget * 12 / 10;

		repeat (3) @(negedge sysClk);
		rst = 1'b0;

		// 1 Reset state and register access
		checkPin(spiCsN, 1'b1, "csN");
		checkPin(spiSck, 1'b0, "SCK");
		checkPin(usiWr.cke, 1'b0, "USI cke");
		checkPin(usiMonopoly, 1'b0, "monopoly");
		for (int a = 0; a <= 16; a += 4)
		begin
			axiRead(8'(a), rd);
			checkAxiRead(rd, 32'h0, "reset register");
		end
		axiWrite(csrDiv, 32'h5);
		axiWrite(csrAdrs, 32'h123456);
		axiWrite(csrLen, 32'hABC);
		axiWrite(csrDest, 32'hBEEF);
		axiRead(csrDiv, rd);
		checkAxiRead(rd, 32'h5, "div");
		axiRead(csrAdrs, rd);
		checkAxiRead(rd, 32'h123456, "flash address");
		axiRead(csrLen, rd);
		checkAxiRead(rd, 32'hABC, "length");
		axiRead(csrDest, rd);
		checkAxiRead(rd, 32'hBEEF, "destination");
		axiRead(8'h14, rd);
		checkAxiRead(rd, 32'h0, "undecoded");

		// 2 Single byte
		startTransfer(24'h00A0F3, 1, 16'h0100, 1);
		waitTransfer();
		axiRead(csrCtrl, rd);
		checkAxiRead(rd, 32'h4, "status after one byte");

		// 3 Random lengths
		for (int i = 0; i < 10; i++)
		begin
			startTransfer(rndAdrs[i], rndCount[i], rndDest[i], 1);
			waitTransfer();
		end

		// 4 Slower SCK
		startTransfer(24'h001000, 8, 16'h2000, 3);
		waitTransfer();
		startTransfer(24'hFFFFFC, 8, 16'h3000, 9);
		waitTransfer();

		// 5 Start while busy is dropped and a new start clears done
		startTransfer(24'h004321, 16, 16'h4000, 1);
		while (!usiMonopoly)
			@(negedge sysClk);
		axiWrite(csrCtrl, 32'h1);
		waitTransfer();
		repeat (40) @(negedge sysClk);
		checkPin(usiMonopoly, 1'b0, "monopoly after ignored start");
		axiRead(csrCtrl, rd);
		checkAxiRead(rd, 32'h4, "status before restart");
		startTransfer(24'h000777, 4, 16'h5000, 1);
		axiRead(csrCtrl, rd);
		checkAxiRead(rd, 32'h2, "status while busy");
		waitTransfer();

		$display("checks %0d, value errors %0d, other errors %0d",
		         checks, valErrors, otherErrors);
		if (valErrors == 0 && otherErrors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/spiUnitAssert.sv
// Protocol checks on the SPI pins and USI bus ownership.
// Bound into every spiUnit instance; silent while rst is high.

`default_nettype none

module spiUnitAssert (
	input wire logic                 sysClk,
	input wire logic                 rst,
	input wire logic                 spiSck,
	input wire logic                 spiCsN,
	input wire usiBusPkg::usiWrite_t usiWr,
	input wire logic                 usiMonopoly
);

	timeunit 1ns;
	timeprecision 100ps;

	// No clock edges while deselected
	sckIdle: assert property (@(posedge sysClk) disable iff (rst) spiCsN |-> !spiSck)
		else $error("SCK high while chip select inactive");

	// Bus writes only as owner
	wrOwned: assert property (@(posedge sysClk) disable iff (rst) usiWr.cke |-> usiMonopoly)
		else $error("USI write without monopoly");

	csOwned: assert property (@(posedge sysClk) disable iff (rst) !usiMonopoly |-> spiCsN)
		else $error("chip select active without monopoly");

endmodule

bind spiUnit spiUnitAssert assert_i (
	.sysClk(sysClk), .rst(rst), .spiSck(spiSck), .spiCsN(spiCsN),
	.usiWr(usiWr), .usiMonopoly(usiMonopoly)
);

`default_nettype wire

//--- testbench/spiFlashModel.sv
// Behavioral serial flash, mode 0, READ (0x03) only.
// Byte at address a is the low byte of a*7 + 0x5A.

`default_nettype none

module spiFlashModel (
	input  wire logic sck,
	input  wire logic csN,
	input  wire logic mosi,
	output logic      miso
);

	timeunit 1ns;
	timeprecision 100ps;

	// Opcode and address as shifted in
	logic [31:0] head;
	int          rises;

	initial
	begin
		miso  = 1'b0;
		head  = '0;
		rises = 0;
	end

	function automatic logic [7:0] flashByte(input logic [23:0] a);
		return 8'((a * 7) + 8'h5A);
	endfunction

	// Deselect restarts the command
	always @(posedge csN)
		rises <= 0;

	// Opcode and address sampled on rising SCK
	always @(posedge sck)
	begin
		if (!csN)
		begin
			if (rises < 32)
				head <= {head[30:0], mosi};
			rises <= rises + 1;
		end
	end

	// Data driven on falling SCK, MSB first
	always @(negedge sck)
	begin
		int          idx;
		logic [23:0] a;
		logic [7:0]  d;
		if (!csN && rises >= 32 && head[31:24] == 8'h03)
		begin
			idx  = rises - 32;
			a    = head[23:0] + 24'(idx / 8);
			d    = flashByte(a);
			miso <= d[7 - (idx % 8)];
		end
		else
			miso <= 1'b0;
	end

endmodule

`default_nettype wire

//--- hdl/spiUnit.sv
// SPI read engine top: AXI4-Lite CSR port, SPI master pins, USI bus master.
// Single chip select, mode 0 only; monopoly is high for a whole transfer.
// divWidth sets the SCK divider width, 2 or more.

`default_nettype none

module spiUnit #(
	parameter int divWidth = 16
)(
	input  wire logic               sysClk,
	input  wire logic               rst,
	// Host control port
	input  wire usiBusPkg::axiReq_t axiReq,
	output usiBusPkg::axiRsp_t      axiRsp,
	// Serial flash pins
	output logic                    spiSck,
	output logic                    spiMosi,
	input  wire logic               spiMiso,
	output logic                    spiCsN,
	// USI bus master
	output usiBusPkg::usiWrite_t    usiWr,
	output logic                    usiMonopoly
);

	import spiPkg::*;

	spiCfg_t             cfg;
	logic                start;
	logic                busy;
	logic                done;
	logic [divWidth-1:0] div;
	logic                cke;
	logic                load;
	logic [7:0]          txByte;
	logic [7:0]          rxByte;
	logic                shifterBusy;
	logic                byteDone;

	// Bus held for the whole transfer
	assign usiMonopoly = busy;

	//----------------------------------------------------------------------
	// Control registers and bit clock
	//----------------------------------------------------------------------
	spiCsr #(.divWidth(divWidth)) csr_i (
		.sysClk(sysClk), .rst(rst), .axiReq(axiReq), .axiRsp(axiRsp),
		.busy(busy), .done(done), .start(start), .div(div), .cfg(cfg)
	);

	ckeGenerator #(.divWidth(divWidth)) cke_i (
		.sysClk(sysClk), .rst(rst), .en(busy), .div(div), .cke(cke)
	);

	//----------------------------------------------------------------------
	// Transfer sequencing and serial shifting
	//----------------------------------------------------------------------
	spiReadSequencer seq_i (
		.sysClk(sysClk), .rst(rst), .start(start), .cfg(cfg), .busy(busy), .done(done),
		.csN(spiCsN), .load(load), .txByte(txByte), .shifterBusy(shifterBusy),
		.byteDone(byteDone), .rxByte(rxByte), .usiWr(usiWr)
	);

	spiShifter shift_i (
		.sysClk(sysClk), .rst(rst), .cke(cke), .load(load), .txByte(txByte),
		.shifterBusy(shifterBusy), .byteDone(byteDone), .rxByte(rxByte),
		.sck(spiSck), .mosi(spiMosi), .miso(spiMiso)
	);

endmodule

`default_nettype wire

//--- hdl/spiReadSequencer.sv
// READ transfer sequencer: opcode, three address bytes, then lenM1+1 data bytes.
// Bytes are packed little-endian; a partial last word is zero-filled.
// cfg is sampled on start, so later CSR writes do not disturb a transfer.

`default_nettype none

module spiReadSequencer (
	input  wire logic            sysClk,
	input  wire logic            rst,
	input  wire logic            start,
	input  wire spiPkg::spiCfg_t cfg,
	output logic                 busy,
	output logic                 done,
	output logic                 csN,
	output logic                 load,
	output logic [7:0]           txByte,
	input  wire logic            shifterBusy,
	input  wire logic            byteDone,
	input  wire logic [7:0]      rxByte,
	output usiBusPkg::usiWrite_t usiWr
);

	import spiPkg::*;
	import usiBusPkg::*;

	typedef enum logic [2:0] {
		stIdle, stCmd, stAdr2, stAdr1, stAdr0, stData, stFinish
	} seqState_t;

	seqState_t                   state;
	// Byte loaded into the shifter, byteDone not yet seen
	logic                        pending;
	logic [spiLenBits-1:0]       remaining;
	logic [1:0]                  lane;
	logic [usiAdrsBits-1:0]      adrsCnt;
	logic [spiFlashAdrsBits-1:0] flashAdrsQ;
	// Word under assembly and its value with the current byte merged
	logic [31:0]                 pack;
	logic [31:0]                 packNext;
	logic                        lastByte;
	logic                        wordFull;
	// Registered USI write
	logic                        wrCke;
	logic [usiDataBits-1:0]      wrData;
	logic [usiAdrsBits-1:0]      wrAdrs;

	assign lastByte = (remaining == '0);
	assign wordFull = (lane == 2'd3);

	// One byte in flight at a time
	assign load = (state inside {stCmd, stAdr2, stAdr1, stAdr0, stData})
	              && !pending && !shifterBusy;

	assign usiWr = '{adrs: wrAdrs, data: wrData, cke: wrCke};

	// Outgoing byte per phase; zeros clock the data in
	always_comb
	begin
		case (state)
			stCmd:   txByte = spiReadCmd;
			stAdr2:  txByte = flashAdrsQ[23:16];
			stAdr1:  txByte = flashAdrsQ[15:8];
			stAdr0:  txByte = flashAdrsQ[7:0];
			default: txByte = 8'h00;
		endcase
	end

	always_comb
	begin
		packNext = pack;
		packNext[{lane, 3'b000} +: 8] = rxByte;
	end

	//----------------------------------------------------------------------
	// Control FSM and counters
	//----------------------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (rst)
		begin
			state     <= stIdle;
			busy      <= 1'b0;
			done      <= 1'b0;
			csN       <= 1'b1;
			pending   <= 1'b0;
			wrCke     <= 1'b0;
			remaining <= '0;
			lane      <= 2'd0;
			adrsCnt   <= '0;
		end
		else
		begin
			done  <= 1'b0;
			wrCke <= 1'b0;
			if (load)
				pending <= 1'b1;
			else if (byteDone)
				pending <= 1'b0;

			case (state)
				stIdle:
					if (start)
					begin
						// CS drops one clock ahead of the opcode load
						state     <= stCmd;
						busy      <= 1'b1;
						csN       <= 1'b0;
						remaining <= cfg.lenM1;
						lane      <= 2'd0;
						adrsCnt   <= cfg.dest;
					end
				stCmd:  if (byteDone) state <= stAdr2;
				stAdr2: if (byteDone) state <= stAdr1;
				stAdr1: if (byteDone) state <= stAdr0;
				stAdr0: if (byteDone) state <= stData;
				stData:
					if (byteDone)
					begin
						lane <= lane + 2'd1;
						if (wordFull || lastByte)
						begin
							wrCke   <= 1'b1;
							adrsCnt <= adrsCnt + usiAdrsBits'(4);
						end
						if (lastByte)
						begin
							state <= stFinish;
							csN   <= 1'b1;
						end
						else
							remaining <= remaining - spiLenBits'(1);
					end
				stFinish:
				begin
					// Bus released after the final write has gone out
					state <= stIdle;
					busy  <= 1'b0;
					done  <= 1'b1;
				end
				default: state <= stIdle;
			endcase
		end
	end

	//----------------------------------------------------------------------
	// Data path
	//----------------------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (state == stIdle && start)
		begin
			flashAdrsQ <= cfg.flashAdrs;
			pack       <= '0;
		end
		else if (state == stData && byteDone)
		begin
			if (wordFull || lastByte)
			begin
				wrData <= packNext;
				wrAdrs <= adrsCnt;
				pack   <= '0;
			end
			else
				pack <= packNext;
		end
	end

endmodule

`default_nettype wire

//--- hdl/spiCsr.sv
// AXI4-Lite slave with the five control registers of the SPI read engine.
// One outstanding read and one outstanding write; responses are always OKAY.
// Byte strobes apply per register; the divider is reachable up to 32 bits.
// A start written while busy is dropped.

`default_nettype none

module spiCsr #(
	parameter int divWidth = 16
)(
	input  wire logic               sysClk,
	input  wire logic               rst,
	input  wire usiBusPkg::axiReq_t axiReq,
	output usiBusPkg::axiRsp_t      axiRsp,
	input  wire logic               busy,
	input  wire logic               done,
	output logic                    start,
	output logic [divWidth-1:0]     div,
	output spiPkg::spiCfg_t         cfg
);

	import spiPkg::*;
	import usiBusPkg::*;

	// Register file
	logic [spiFlashAdrsBits-1:0] adrsReg;
	logic [spiLenBits-1:0]       lenReg;
	logic [usiAdrsBits-1:0]      destReg;
	logic                        doneFlag;

	// Channel state
	logic                   bvalid;
	logic                   rvalid;
	logic [axiDataBits-1:0] rdata;
	logic                   wrTake;
	logic                   rdTake;
	logic [axiDataBits-1:0] rdMux;

	// Byte lanes with strobe set replace the old value
	function automatic logic [31:0] strbMerge(
		input logic [31:0] old,
		input logic [31:0] data,
		input logic [3:0]  strb
	);
		logic [31:0] res;
		res = old;
		for (int i = 0; i < 4; i++)
			if (strb[i])
				res[i*8 +: 8] = data[i*8 +: 8];
		return res;
	endfunction

	// Handshakes, one access in flight per channel
	assign wrTake = axiReq.awvalid && axiReq.wvalid && !bvalid;
	assign rdTake = axiReq.arvalid && !rvalid;

	assign axiRsp = '{awready: !bvalid, wready: !bvalid, bresp: 2'b00, bvalid: bvalid,
	                  arready: !rvalid, rdata: rdata, rresp: 2'b00, rvalid: rvalid};

	assign cfg = '{flashAdrs: adrsReg, lenM1: lenReg, dest: destReg};

	//----------------------------------------------------------------------
	// Write channel and register updates
	//----------------------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (rst)
		begin
			div      <= '0;
			adrsReg  <= '0;
			lenReg   <= '0;
			destReg  <= '0;
			doneFlag <= 1'b0;
			start    <= 1'b0;
			bvalid   <= 1'b0;
		end
		else
		begin
			start <= 1'b0;
			// Response held until the host takes it
			if (wrTake)
				bvalid <= 1'b1;
			else if (axiReq.bready)
				bvalid <= 1'b0;

			if (wrTake)
			begin
				case (axiReq.awaddr)
					csrCtrl: start <= axiReq.wstrb[0] && axiReq.wdata[ctrlStartBit] && !busy;
					csrDiv:  div <= divWidth'(strbMerge(32'(div), axiReq.wdata, axiReq.wstrb));
					csrAdrs: adrsReg <= spiFlashAdrsBits'(strbMerge(32'(adrsReg),
					                                                axiReq.wdata, axiReq.wstrb));
					csrLen:  lenReg <= spiLenBits'(strbMerge(32'(lenReg), axiReq.wdata, axiReq.wstrb));
					csrDest: destReg <= usiAdrsBits'(strbMerge(32'(destReg),
					                                           axiReq.wdata, axiReq.wstrb));
					default: ;
				endcase
			end

			// Sticky done, cleared by a new start
			if (start)
				doneFlag <= 1'b0;
			else if (done)
				doneFlag <= 1'b1;
		end
	end

	//----------------------------------------------------------------------
	// Read channel
	//----------------------------------------------------------------------
	always_comb
	begin
		rdMux = '0;
		case (axiReq.araddr)
			csrCtrl:
			begin
				rdMux[ctrlBusyBit] = busy;
				rdMux[ctrlDoneBit] = doneFlag;
			end
			csrDiv:  rdMux = axiDataBits'(div);
			csrAdrs: rdMux = axiDataBits'(adrsReg);
			csrLen:  rdMux = axiDataBits'(lenReg);
			csrDest: rdMux = axiDataBits'(destReg);
			default: rdMux = '0;  // undecoded reads as zero
		endcase
	end

	always_ff @(posedge sysClk)
	begin
		if (rst)
			rvalid <= 1'b0;
		else if (rdTake)
			rvalid <= 1'b1;
		else if (axiReq.rready)
			rvalid <= 1'b0;
	end

	// Read data captured with the address
	always_ff @(posedge sysClk)
	begin
		if (rdTake)
			rdata <= rdMux;
	end

endmodule

`default_nettype wire

//--- hdl/spiShifter.sv
// One-byte SPI mode 0 master shifter, MSB first.
// Each bit uses two cke pulses: SCK rises (sample MISO) then falls (next MOSI).
// load is honoured only while shifterBusy is low; cke is ignored when idle.

`default_nettype none

module spiShifter (
	input  wire logic       sysClk,
	input  wire logic       rst,
	input  wire logic       cke,
	input  wire logic       load,
	input  wire logic [7:0] txByte,
	output logic            shifterBusy,
	output logic            byteDone,
	output logic [7:0]      rxByte,
	output logic            sck,
	output logic            mosi,
	input  wire logic       miso
);

	// Transmit shift register, MSB drives MOSI
	logic [7:0] txShift;
	// Receive shift register
	logic [7:0] rxShift;
	// Bit index within the byte
	logic [2:0] bitCnt;

	assign mosi   = txShift[7];
	assign rxByte = rxShift;

	//----------------------------------------------------------------------
	// SCK phase, bit counter and transmit path
	//----------------------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (rst)
		begin
			shifterBusy <= 1'b0;
			byteDone    <= 1'b0;
			sck         <= 1'b0;
			bitCnt      <= 3'd0;
			// Keeps MOSI low out of reset
			txShift     <= 8'h00;
		end
		else
		begin
			byteDone <= 1'b0;
			if (!shifterBusy)
			begin
				// New byte, first bit on MOSI while SCK low
				if (load)
				begin
					shifterBusy <= 1'b1;
					txShift     <= txByte;
					bitCnt      <= 3'd0;
				end
			end
			else if (cke)
			begin
				if (!sck)
				begin
					// Rising edge
					sck <= 1'b1;
				end
				else
				begin
					// Falling edge
					sck <= 1'b0;
					if (bitCnt == 3'd7)
					begin
						// Eighth bit already sampled on the rise
						shifterBusy <= 1'b0;
						byteDone    <= 1'b1;
					end
					else
					begin
						bitCnt  <= bitCnt + 3'd1;
						txShift <= {txShift[6:0], 1'b0};
					end
				end
			end
		end
	end

	//----------------------------------------------------------------------
	// Receive path
	//----------------------------------------------------------------------
	// MISO captured on the cke that raises SCK
	always_ff @(posedge sysClk)
	begin
		if (shifterBusy && cke && !sck)
		begin
			rxShift <= {rxShift[6:0], miso};
		end
	end

endmodule

`default_nettype wire

//--- hdl/ckeGenerator.sv
// Clock-enable pulse every div+1 clocks while en is high.
// A div of zero behaves as one, so the pulse period is at least two clocks.
// The counter restarts whenever en drops.

`default_nettype none

module ckeGenerator #(
	parameter int divWidth = 16
)(
	input  wire logic                sysClk,
	input  wire logic                rst,
	input  wire logic                en,
	input  wire logic [divWidth-1:0] div,
	output logic                     cke
);

	// Terminal count after clamping
	logic [divWidth-1:0] divEff;
	// Clocks since last pulse
	logic [divWidth-1:0] count;

	// Divider below 1 treated as 1
	assign divEff = (div == '0) ? divWidth'(1) : div;

	//----------------------------------------------------------------------
	// Counter and pulse
	//----------------------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (rst || !en)
		begin
			// Held at zero so the first pulse lands div+1 clocks after en
			count <= '0;
			cke   <= 1'b0;
		end
		else if (count == divEff)
		begin
			count <= '0;
			cke   <= 1'b1;
		end
		else
		begin
			count <= count + divWidth'(1);
			cke   <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hdl/spiPkg.sv
// Serial-flash protocol constants and the CSR map of the read engine.
// Compile after usiBusPkg; the config struct uses its address width.
// Only the plain READ command (0x03, 24-bit address) is supported.

`default_nettype none

package spiPkg;

	// Serial flash READ opcode
	localparam logic [7:0] spiReadCmd = 8'h03;

	// CSR byte offsets
	localparam logic [7:0] csrCtrl = 8'h00;
	localparam logic [7:0] csrDiv  = 8'h04;
	localparam logic [7:0] csrAdrs = 8'h08;
	localparam logic [7:0] csrLen  = 8'h0C;
	localparam logic [7:0] csrDest = 8'h10;

	// Control/status bit positions
	localparam int ctrlStartBit = 0;
	localparam int ctrlBusyBit  = 1;
	localparam int ctrlDoneBit  = 2;

	// Byte count minus one, up to 4096 bytes per transfer
	localparam int spiLenBits = 12;
	// Flash address width of the READ command
	localparam int spiFlashAdrsBits = 24;

	// Transfer setup from CSR block to sequencer
	typedef struct packed {
		logic [spiFlashAdrsBits-1:0]        flashAdrs;
		logic [spiLenBits-1:0]              lenM1;
		logic [usiBusPkg::usiAdrsBits-1:0] dest;
	} spiCfg_t;

endpackage

`default_nettype wire

//--- hdl/usiBusPkg.sv
// Bus-side types shared by the SPI read engine and its host.
// AXI4-Lite subset with 8-bit addresses and a 32-bit data path.
// USI writes carry no back-pressure, so one write per cycle is accepted.

`default_nettype none

package usiBusPkg;

	// USI system bus widths
	localparam int usiAdrsBits = 16;
	localparam int usiDataBits = 32;

	// AXI4-Lite control port widths
	localparam int axiAdrsBits = 8;
	localparam int axiDataBits = 32;

	// One USI bus write, valid while cke is high
	typedef struct packed {
		logic [usiAdrsBits-1:0] adrs;
		logic [usiDataBits-1:0] data;
		logic                   cke;
	} usiWrite_t;

	// Host to slave
	typedef struct packed {
		logic [axiAdrsBits-1:0]   awaddr;
		logic                     awvalid;
		logic [axiDataBits-1:0]   wdata;
		logic [axiDataBits/8-1:0] wstrb;
		logic                     wvalid;
		logic                     bready;
		logic [axiAdrsBits-1:0]   araddr;
		logic                     arvalid;
		logic                     rready;
	} axiReq_t;

	// Slave to host
	typedef struct packed {
		logic                   awready;
		logic                   wready;
		logic [1:0]             bresp;
		logic                   bvalid;
		logic                   arready;
		logic [axiDataBits-1:0] rdata;
		logic [1:0]             rresp;
		logic                   rvalid;
	} axiRsp_t;

endpackage

`default_nettype wire
